//--- access_check.sv
// Enables, faults and miss decisions
`timescale 1ns/1ns
`default_nettype none

module access_check
(
    input wire logic req_valid,
    input wire logic req_is_load,
    input wire logic req_tlb_hit,
    input wire logic req_tlb_present,
    input wire logic req_tlb_writable,
    input wire logic hit,
    input wire logic near_miss_tag,
    input wire logic [l1d_geometry_pkg::LINE_BYTES-1:0] store_mask,
    input wire logic unaligned,
    output logic load_en,
    output logic read_en,
    output logic fault,
    output mem_op_pkg::fault_t fault_reason,
    output logic miss,
    output logic retry,
    output logic store_go,
    output logic lru_go
);

    logic store_path;
    logic access_en;
    logic tlb_miss;
    logic page_fault;
    logic alignment_fault;
    logic write_fault;
    logic load_miss;

    assign load_en = req_valid && req_is_load && req_tlb_hit;

    // A store with an empty mask writes nothing and is dropped
    assign store_path = req_valid && req_tlb_hit && !req_is_load && |store_mask;
    assign access_en = load_en || store_path;

    assign tlb_miss = req_valid && !req_tlb_hit;
    assign page_fault = access_en && !req_tlb_present;
    assign alignment_fault = access_en && unaligned;
    assign write_fault = store_path && !req_tlb_writable;
    assign fault = tlb_miss || page_fault || alignment_fault || write_fault;

    // Permission bits mean nothing after a TLB miss, so it goes first
    always_comb
    begin
        if (tlb_miss)
            fault_reason = mem_op_pkg::FR_TLB_MISS;
        else if (page_fault)
            fault_reason = mem_op_pkg::FR_PAGE_FAULT;
        else if (alignment_fault)
            fault_reason = mem_op_pkg::FR_ALIGNMENT;
        else
            fault_reason = mem_op_pkg::FR_WRITE;
    end

    assign read_en = load_en && hit;

    // Missing loads always roll back.
    // Only a true miss goes to L2; a near miss just retries
    assign load_miss = load_en && !hit && !fault;
    assign retry = load_miss;
    assign miss = load_miss && !near_miss_tag;

    assign store_go = store_path && !fault;
    assign lru_go = hit && access_en && !fault;

endmodule

`default_nettype wire

//--- dcache_data_stage.sv
// L1 data cache data stage
`timescale 1ns/1ns
`default_nettype none

module dcache_data_stage
(
    input wire logic clk,
    input wire logic reset,

    // Request from the tag stage
    input wire logic req_valid,
    input wire logic req_is_load,
    input wire mem_op_pkg::access_t req_access,
    input wire logic [l1d_geometry_pkg::ADDR_BITS-1:0] req_paddr,
    input wire logic [l1d_geometry_pkg::LINE_WORDS-1:0] req_lane_mask,
    input wire l1d_geometry_pkg::line_t req_store_value,
    input wire logic [l1d_geometry_pkg::THREAD_IDX_BITS-1:0] req_thread_idx,
    input wire logic req_tlb_hit,
    input wire logic req_tlb_present,
    input wire logic req_tlb_writable,
    input wire logic [l1d_geometry_pkg::WAYS-1:0] way_valid,
    input wire logic [l1d_geometry_pkg::WAYS-1:0][l1d_geometry_pkg::TAG_BITS-1:0] way_tag,

    // Fills from L2
    input wire logic fill_en,
    input wire logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] fill_way,
    input wire logic [l1d_geometry_pkg::SET_BITS-1:0] fill_set,
    input wire l1d_geometry_pkg::line_t fill_data,
    input wire logic tag_fill_en,
    input wire logic [l1d_geometry_pkg::SET_BITS-1:0] tag_fill_set,
    input wire logic [l1d_geometry_pkg::TAG_BITS-1:0] tag_fill_tag,

    // Response to writeback
    output logic resp_valid,
    output logic [l1d_geometry_pkg::THREAD_IDX_BITS-1:0] resp_thread_idx,
    output logic resp_fault,
    output mem_op_pkg::fault_t resp_fault_reason,
    output logic resp_suspend,
    output logic resp_rollback,
    output l1d_geometry_pkg::line_t resp_load_data,

    // LRU update to the tag stage
    output logic lru_update_en,
    output logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] lru_update_way,

    // Requests to L2
    output logic miss_en,
    output logic [l1d_geometry_pkg::ADDR_BITS-1:0] miss_addr,
    output logic [l1d_geometry_pkg::THREAD_IDX_BITS-1:0] miss_thread_idx,
    output logic store_en,
    output logic [l1d_geometry_pkg::ADDR_BITS-1:0] store_addr,
    output logic [l1d_geometry_pkg::LINE_BYTES-1:0] store_mask_out,
    output l1d_geometry_pkg::line_t store_data_out
);

    logic hit;
    logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] hit_way;
    logic near_miss_tag;
    logic [l1d_geometry_pkg::LINE_BYTES-1:0] store_mask;
    l1d_geometry_pkg::line_t store_data;
    logic unaligned;
    logic read_en;
    logic fault;
    mem_op_pkg::fault_t fault_reason;
    logic miss;
    logic retry;
    logic store_go;
    logic lru_go;

    way_hit_detect u_hit (.*);

    store_align u_align (.*);

    access_check u_check (.load_en(), .*);

    line_data_ram u_ram
    (
        .clk(clk),
        .read_en(read_en),
        .read_way(hit_way),
        .read_set(req_paddr[l1d_geometry_pkg::OFFSET_BITS +: l1d_geometry_pkg::SET_BITS]),
        .fill_en(fill_en),
        .fill_way(fill_way),
        .fill_set(fill_set),
        .fill_data(fill_data),
        .read_data(resp_load_data)
    );

    response_register u_resp (.*);

endmodule

`default_nettype wire

//--- l1d_geometry_pkg.sv
// L1 data cache geometry
`default_nettype none

package l1d_geometry_pkg;

    // Physical address width
    localparam int ADDR_BITS = 32;

    // Organization
    localparam int WAYS = 4;
    localparam int SETS = 64;
    localparam int LINE_BYTES = 64;
    localparam int WORD_BITS = 32;
    localparam int LINE_WORDS = LINE_BYTES / (WORD_BITS / 8);

    // Hardware threads sharing the pipeline
    localparam int THREADS = 4;
    localparam int THREAD_IDX_BITS = $clog2(THREADS);

    // Address split, from the top: tag, set, offset
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int SET_BITS = $clog2(SETS);
    localparam int TAG_BITS = ADDR_BITS - SET_BITS - OFFSET_BITS;
    localparam int WAY_IDX_BITS = $clog2(WAYS);

    // One cache line, big-endian.
    // Both views count upward from the most significant end, so byte k is
    // line offset k and word w covers offsets 4w..4w+3 with 4w on top
    typedef union packed
    {
        logic [0:LINE_WORDS-1][WORD_BITS-1:0] words;
        logic [0:LINE_BYTES-1][7:0] bytes;
    } line_t;

endpackage

`default_nettype wire

//--- line_data_ram.sv
// Cache line data store
`timescale 1ns/1ns
`default_nettype none

module line_data_ram
(
    input wire logic clk,
    input wire logic read_en,
    input wire logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] read_way,
    input wire logic [l1d_geometry_pkg::SET_BITS-1:0] read_set,
    input wire logic fill_en,
    input wire logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] fill_way,
    input wire logic [l1d_geometry_pkg::SET_BITS-1:0] fill_set,
    input wire l1d_geometry_pkg::line_t fill_data,
    output l1d_geometry_pkg::line_t read_data
);

    l1d_geometry_pkg::line_t lines [l1d_geometry_pkg::WAYS * l1d_geometry_pkg::SETS];
    logic [l1d_geometry_pkg::WAY_IDX_BITS + l1d_geometry_pkg::SET_BITS - 1:0] read_addr;
    logic [l1d_geometry_pkg::WAY_IDX_BITS + l1d_geometry_pkg::SET_BITS - 1:0] fill_addr;

    // Entry index is way then set
    assign read_addr = {read_way, read_set};
    assign fill_addr = {fill_way, fill_set};

    always_ff @(posedge clk)
    begin
        if (fill_en)
            lines[fill_addr] <= fill_data;

        // Read during write returns the new line
        if (read_en)
        begin
            if (fill_en && fill_addr == read_addr)
                read_data <= fill_data;
            else
                read_data <= lines[read_addr];
        end
    end

endmodule

`default_nettype wire

//--- mem_op_pkg.sv
// Memory access and fault encodings
`default_nettype none

package mem_op_pkg;

    // Access size of a load or store
    typedef enum logic [1:0]
    {
        // Single byte
        MEM_B = 2'd0,
        // Halfword, two bytes
        MEM_S = 2'd1,
        // Word, four bytes
        MEM_L = 2'd2,
        // Block vector, one word per lane across the whole line
        MEM_BLOCK = 2'd3
    } access_t;

    // Fault reason reported with resp_fault.
    // Listed from highest to lowest priority
    typedef enum logic [1:0]
    {
        // No translation for the address
        FR_TLB_MISS = 2'd0,
        // Translation exists but the page is not present
        FR_PAGE_FAULT = 2'd1,
        // Address not aligned to the access size
        FR_ALIGNMENT = 2'd2,
        // Store to a read-only page
        FR_WRITE = 2'd3
    } fault_t;

endpackage

`default_nettype wire

//--- response_register.sv
// Stage output register
`timescale 1ns/1ns
`default_nettype none

module response_register
(
    input wire logic clk,
    input wire logic reset,
    input wire logic req_valid,
    input wire logic [l1d_geometry_pkg::THREAD_IDX_BITS-1:0] req_thread_idx,
    input wire logic [l1d_geometry_pkg::ADDR_BITS-1:0] req_paddr,
    input wire logic fault,
    input wire mem_op_pkg::fault_t fault_reason,
    input wire logic miss,
    input wire logic retry,
    input wire logic store_go,
    input wire logic lru_go,
    input wire logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] hit_way,
    input wire logic [l1d_geometry_pkg::LINE_BYTES-1:0] store_mask,
    input wire l1d_geometry_pkg::line_t store_data,
    output logic resp_valid,
    output logic [l1d_geometry_pkg::THREAD_IDX_BITS-1:0] resp_thread_idx,
    output logic resp_fault,
    output mem_op_pkg::fault_t resp_fault_reason,
    output logic resp_suspend,
    output logic resp_rollback,
    output logic lru_update_en,
    output logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] lru_update_way,
    output logic miss_en,
    output logic [l1d_geometry_pkg::ADDR_BITS-1:0] miss_addr,
    output logic [l1d_geometry_pkg::THREAD_IDX_BITS-1:0] miss_thread_idx,
    output logic store_en,
    output logic [l1d_geometry_pkg::ADDR_BITS-1:0] store_addr,
    output logic [l1d_geometry_pkg::LINE_BYTES-1:0] store_mask_out,
    output l1d_geometry_pkg::line_t store_data_out
);

    always_ff @(posedge clk)
    begin
        resp_thread_idx <= req_thread_idx;
        resp_fault_reason <= fault_reason;
        lru_update_way <= hit_way;
        // L2 fetches whole lines
        miss_addr <= {req_paddr[l1d_geometry_pkg::ADDR_BITS-1:l1d_geometry_pkg::OFFSET_BITS],
            {l1d_geometry_pkg::OFFSET_BITS{1'b0}}};
        miss_thread_idx <= req_thread_idx;
        store_addr <= req_paddr;
        store_mask_out <= store_mask;
        store_data_out <= store_data;
    end

    always_ff @(posedge clk, posedge reset)
    begin
        if (reset)
        begin
            resp_valid <= 1'b0;
            resp_fault <= 1'b0;
            resp_suspend <= 1'b0;
            resp_rollback <= 1'b0;
            lru_update_en <= 1'b0;
            miss_en <= 1'b0;
            store_en <= 1'b0;
        end
        else
        begin
            resp_valid <= req_valid;
            resp_fault <= fault;
            // Thread sleeps until the fill for its miss wakes it
            resp_suspend <= miss;
            resp_rollback <= retry;
            lru_update_en <= lru_go;
            miss_en <= miss;
            store_en <= store_go;
        end
    end

    // A request is either a load or a store, never both on the L2 side
    miss_store_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(miss_en && store_en));

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_dcache_data_stage -f verilog.f

output=$(./obj_dir/Vtb_dcache_data_stage 2>&1) || true
echo "$output"

if echo "$output" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

//--- store_align.sv
// Store data alignment and byte mask
`timescale 1ns/1ns
`default_nettype none

module store_align
(
    input wire mem_op_pkg::access_t req_access,
    input wire logic [l1d_geometry_pkg::ADDR_BITS-1:0] req_paddr,
    input wire logic [l1d_geometry_pkg::LINE_WORDS-1:0] req_lane_mask,
    input wire l1d_geometry_pkg::line_t req_store_value,
    output logic [l1d_geometry_pkg::LINE_BYTES-1:0] store_mask,
    output l1d_geometry_pkg::line_t store_data,
    output logic unaligned
);

    logic [l1d_geometry_pkg::OFFSET_BITS-1:0] offset;
    logic [l1d_geometry_pkg::WORD_BITS-1:0] scalar_value;
    logic [l1d_geometry_pkg::LINE_BYTES-1:0] scalar_mask;
    logic [l1d_geometry_pkg::LINE_BYTES-1:0] block_mask;

    assign offset = req_paddr[l1d_geometry_pkg::OFFSET_BITS-1:0];

    // Scalar stores take their value from lane 0
    assign scalar_value = req_store_value.words[0];

    // Block store, each lane mask bit covers the four bytes of its word
    for (genvar k = 0; k < l1d_geometry_pkg::LINE_BYTES; k++)
    begin : block_mask_gen
        assign block_mask[k] = req_lane_mask[k / 4];
    end

    // Scalar store, enable the bytes that share the access-sized slot
    always_comb
    begin
        logic [l1d_geometry_pkg::OFFSET_BITS-1:0] byte_off;

        scalar_mask = '0;
        for (int k = 0; k < l1d_geometry_pkg::LINE_BYTES; k++)
        begin
            byte_off = k[l1d_geometry_pkg::OFFSET_BITS-1:0];
            case (req_access)
                mem_op_pkg::MEM_B:
                    scalar_mask[k] = byte_off == offset;
                mem_op_pkg::MEM_S:
                    scalar_mask[k] = byte_off[l1d_geometry_pkg::OFFSET_BITS-1:1]
                        == offset[l1d_geometry_pkg::OFFSET_BITS-1:1];
                mem_op_pkg::MEM_L:
                    scalar_mask[k] = byte_off[l1d_geometry_pkg::OFFSET_BITS-1:2]
                        == offset[l1d_geometry_pkg::OFFSET_BITS-1:2];
                default:
                    scalar_mask[k] = 1'b0;
            endcase
        end
    end

    assign store_mask = req_access == mem_op_pkg::MEM_BLOCK ? block_mask : scalar_mask;

    // Replicate the scalar across the line so every slot already holds it.
    // Most significant byte lands on the lowest offset
    always_comb
    begin
        case (req_access)
            mem_op_pkg::MEM_B:
                store_data.bytes = {l1d_geometry_pkg::LINE_BYTES{scalar_value[7:0]}};
            mem_op_pkg::MEM_S:
                store_data.words = {l1d_geometry_pkg::LINE_WORDS{scalar_value[15:0],
                    scalar_value[15:0]}};
            mem_op_pkg::MEM_L:
                store_data.words = {l1d_geometry_pkg::LINE_WORDS{scalar_value}};
            default:
                store_data = req_store_value;
        endcase
    end

    // Misalignment for the access size
    always_comb
    begin
        case (req_access)
            mem_op_pkg::MEM_S:     unaligned = offset[0];
            mem_op_pkg::MEM_L:     unaligned = |offset[1:0];
            mem_op_pkg::MEM_BLOCK: unaligned = |offset;
            default:               unaligned = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- tb_dcache_data_stage.sv
// Data stage testbench
`timescale 1ns/1ns
`default_nettype none

module tb_dcache_data_stage;

    // Expected outputs of one request
    typedef struct packed
    {
        logic valid;
        logic [l1d_geometry_pkg::THREAD_IDX_BITS-1:0] thread;
        logic fault;
        mem_op_pkg::fault_t reason;
        logic rollback;
        logic miss;
        logic lru_en;
        logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] lru_way;
        logic [l1d_geometry_pkg::ADDR_BITS-1:0] miss_addr;
        logic store_en;
        logic [l1d_geometry_pkg::ADDR_BITS-1:0] store_addr;
        logic [l1d_geometry_pkg::LINE_BYTES-1:0] store_mask;
        l1d_geometry_pkg::line_t store_data;
        logic check_load;
        l1d_geometry_pkg::line_t load_data;
    } result_t;

    logic clk;
    logic reset;
    logic req_valid;
    logic req_is_load;
    mem_op_pkg::access_t req_access;
    logic [l1d_geometry_pkg::ADDR_BITS-1:0] req_paddr;
    logic [l1d_geometry_pkg::LINE_WORDS-1:0] req_lane_mask;
    l1d_geometry_pkg::line_t req_store_value;
    logic [l1d_geometry_pkg::THREAD_IDX_BITS-1:0] req_thread_idx;
    logic req_tlb_hit;
    logic req_tlb_present;
    logic req_tlb_writable;
    logic [l1d_geometry_pkg::WAYS-1:0] way_valid;
    logic [l1d_geometry_pkg::WAYS-1:0][l1d_geometry_pkg::TAG_BITS-1:0] way_tag;
    logic fill_en;
    logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] fill_way;
    logic [l1d_geometry_pkg::SET_BITS-1:0] fill_set;
    l1d_geometry_pkg::line_t fill_data;
    logic tag_fill_en;
    logic [l1d_geometry_pkg::SET_BITS-1:0] tag_fill_set;
    logic [l1d_geometry_pkg::TAG_BITS-1:0] tag_fill_tag;
    logic resp_valid;
    logic [l1d_geometry_pkg::THREAD_IDX_BITS-1:0] resp_thread_idx;
    logic resp_fault;
    mem_op_pkg::fault_t resp_fault_reason;
    logic resp_suspend;
    logic resp_rollback;
    l1d_geometry_pkg::line_t resp_load_data;
    logic lru_update_en;
    logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] lru_update_way;
    logic miss_en;
    logic [l1d_geometry_pkg::ADDR_BITS-1:0] miss_addr;
    logic [l1d_geometry_pkg::THREAD_IDX_BITS-1:0] miss_thread_idx;
    logic store_en;
    logic [l1d_geometry_pkg::ADDR_BITS-1:0] store_addr;
    logic [l1d_geometry_pkg::LINE_BYTES-1:0] store_mask_out;
    l1d_geometry_pkg::line_t store_data_out;

    // Line RAM model, indexed by way then set
    l1d_geometry_pkg::line_t model [l1d_geometry_pkg::WAYS * l1d_geometry_pkg::SETS];
    result_t want_next;
    result_t want;
    logic armed;
    int cycles = 0;

    dcache_data_stage dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Expectations move one stage along with their request
    always @(posedge clk)
        want <= want_next;

    always @(posedge clk, posedge reset)
    begin
        if (reset)
            armed <= 1'b0;
        else
            armed <= 1'b1;
    end

    // About four times the length of the whole test sequence
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles == 2000)
        begin
            $display("Timeout: the run did not finish within 2000 cycles");
            $display("TESTS FAILED");
            $fatal(1, "simulation stopped by timeout");
        end
    end

    task automatic mismatch(input string name, input logic [511:0] expected,
        input logic [511:0] actual);
        $display("ERROR at %0t ns: %s expected %0h, actual %0h", $time, name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "output mismatch");
    endtask

    function automatic logic [l1d_geometry_pkg::TAG_BITS-1:0] tag_of(input logic [31:0] addr);
        return addr[l1d_geometry_pkg::ADDR_BITS-1 -: l1d_geometry_pkg::TAG_BITS];
    endfunction

    function automatic logic [l1d_geometry_pkg::SET_BITS-1:0] set_of(input logic [31:0] addr);
        return addr[l1d_geometry_pkg::OFFSET_BITS +: l1d_geometry_pkg::SET_BITS];
    endfunction

    function automatic int entry_of(input int way, input int set);
        return way * l1d_geometry_pkg::SETS + set;
    endfunction

    function automatic l1d_geometry_pkg::line_t random_line();
        l1d_geometry_pkg::line_t line;
        for (int w = 0; w < l1d_geometry_pkg::LINE_WORDS; w++)
            line.words[w] = $urandom();
        return line;
    endfunction

    // Expected outputs of the request now on the inputs, from the stage rules
    function automatic void predict();
        logic [l1d_geometry_pkg::TAG_BITS-1:0] tag;
        logic [l1d_geometry_pkg::SET_BITS-1:0] set;
        logic [l1d_geometry_pkg::WORD_BITS-1:0] value;
        logic [l1d_geometry_pkg::LINE_BYTES-1:0] mask;
        l1d_geometry_pkg::line_t aligned;
        logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] way;
        logic way_hit;
        logic misaligned;
        logic load_en;
        logic store_path;
        logic access_en;
        logic fault;
        int offs;
        int size;
        int base;

        tag = tag_of(req_paddr);
        set = set_of(req_paddr);
        offs = int'(req_paddr[l1d_geometry_pkg::OFFSET_BITS-1:0]);
        value = req_store_value.words[0];

        way_hit = 1'b0;
        way = '0;
        for (int w = 0; w < l1d_geometry_pkg::WAYS; w++)
        begin
            if (way_valid[w] && way_tag[w] == tag)
            begin
                way_hit = 1'b1;
                way = w[l1d_geometry_pkg::WAY_IDX_BITS-1:0];
            end
        end
        way_hit = way_hit && req_tlb_hit;

        mask = '0;
        aligned = req_store_value;
        if (req_access == mem_op_pkg::MEM_BLOCK)
        begin
            for (int k = 0; k < l1d_geometry_pkg::LINE_BYTES; k++)
                mask[k] = req_lane_mask[k / 4];
            misaligned = offs != 0;
        end
        else
        begin
            size = 1 << int'(req_access);
            base = offs - offs % size;
            misaligned = offs != base;
            for (int k = base; k < base + size; k++)
                mask[k] = 1'b1;
            // Big-endian, the last byte of each slot carries the low value bits
            for (int k = 0; k < l1d_geometry_pkg::LINE_BYTES; k++)
                aligned.bytes[k] = value[8 * (size - 1 - k % size) +: 8];
        end

        load_en = req_valid && req_is_load && req_tlb_hit;
        store_path = req_valid && req_tlb_hit && !req_is_load && mask != '0;
        access_en = load_en || store_path;
        fault = (req_valid && !req_tlb_hit) || (access_en && !req_tlb_present)
            || (access_en && misaligned) || (store_path && !req_tlb_writable);

        want_next.valid = req_valid;
        want_next.thread = req_thread_idx;
        want_next.fault = fault;
        if (req_valid && !req_tlb_hit)
            want_next.reason = mem_op_pkg::FR_TLB_MISS;
        else if (!req_tlb_present)
            want_next.reason = mem_op_pkg::FR_PAGE_FAULT;
        else if (misaligned)
            want_next.reason = mem_op_pkg::FR_ALIGNMENT;
        else
            want_next.reason = mem_op_pkg::FR_WRITE;
        want_next.rollback = load_en && !way_hit && !fault;
        want_next.miss = want_next.rollback
            && !(tag_fill_en && tag_fill_set == set && tag_fill_tag == tag);
        want_next.lru_en = way_hit && access_en && !fault;
        want_next.lru_way = way;
        want_next.miss_addr = req_paddr;
        want_next.miss_addr[l1d_geometry_pkg::OFFSET_BITS-1:0] = '0;
        want_next.store_en = store_path && !fault;
        want_next.store_addr = req_paddr;
        want_next.store_mask = mask;
        want_next.store_data = aligned;
        want_next.check_load = want_next.lru_en && req_is_load;

        // A fill to the entry being read wins
        if (fill_en && fill_way == way && fill_set == set)
            want_next.load_data = fill_data;
        else
            want_next.load_data = model[entry_of(int'(way), int'(set))];
        if (fill_en)
            model[entry_of(int'(fill_way), int'(fill_set))] = fill_data;
    endfunction

    task automatic random_request();
        logic [31:0] r;
        r = $urandom();
        req_valid = 1'b1;
        req_is_load = r[0];
        req_access = mem_op_pkg::access_t'(r[2:1]);
        req_thread_idx = r[3 +: l1d_geometry_pkg::THREAD_IDX_BITS];
        way_valid = r[8 +: l1d_geometry_pkg::WAYS];
        req_lane_mask = r[16 +: l1d_geometry_pkg::LINE_WORDS];
        req_tlb_hit = 1'b1;
        req_tlb_present = 1'b1;
        req_tlb_writable = 1'b1;
        req_paddr = $urandom();
        req_store_value = random_line();
        fill_en = 1'b0;
        tag_fill_en = 1'b0;
    endtask

    task automatic align_address();
        case (req_access)
            mem_op_pkg::MEM_S:     req_paddr[0] = 1'b0;
            mem_op_pkg::MEM_L:     req_paddr[1:0] = 2'b00;
            mem_op_pkg::MEM_BLOCK: req_paddr[l1d_geometry_pkg::OFFSET_BITS-1:0] = '0;
            default:               ;
        endcase
    endtask

    // Distinct tags in every way, the request's own tag only in hit_way
    task automatic place_tags(input int hit_way);
        logic [l1d_geometry_pkg::TAG_BITS-1:0] other;
        other = tag_of(req_paddr);
        for (int w = 0; w < l1d_geometry_pkg::WAYS; w++)
        begin
            other = other + 1;
            way_tag[w] = w == hit_way ? tag_of(req_paddr) : other;
            if (w == hit_way)
                way_valid[w] = 1'b1;
        end
    endtask

    task automatic hit_load_checks(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            random_request();
            req_valid = 1'b0;
            r = $urandom();
            fill_en = 1'b1;
            fill_way = r[l1d_geometry_pkg::WAY_IDX_BITS-1:0];
            fill_set = r[4 +: l1d_geometry_pkg::SET_BITS];
            fill_data = random_line();
            predict();
            // Read it back, now and then while a new fill overwrites it
            @(negedge clk);
            random_request();
            req_is_load = 1'b1;
            align_address();
            req_paddr[l1d_geometry_pkg::OFFSET_BITS +: l1d_geometry_pkg::SET_BITS] = fill_set;
            place_tags(int'(fill_way));
            r = $urandom();
            fill_en = r[1:0] == 2'b00;
            fill_data = random_line();
            predict();
        end
    endtask

    task automatic load_miss_checks(input int n, input logic near);
        logic [31:0] r;
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            random_request();
            req_is_load = 1'b1;
            align_address();
            place_tags(-1);
            r = $urandom();
            tag_fill_en = near || r[0];
            tag_fill_set = near ? set_of(req_paddr) : ~set_of(req_paddr);
            tag_fill_tag = tag_of(req_paddr);
            predict();
        end
    endtask

    task automatic store_checks(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            random_request();
            req_is_load = 1'b0;
            align_address();
            r = $urandom();
            place_tags(r[2] ? int'(r[1:0]) : -1);
            predict();
        end
    endtask

    // Loads never hit here, the lines they would read were never filled
    task automatic fault_checks(input int n);
        logic [31:0] r;
        for (int i = 0; i < n; i++)
        begin
            @(negedge clk);
            random_request();
            r = $urandom();
            req_valid = r[0] || r[1];
            req_tlb_hit = r[2] || r[3];
            req_tlb_present = r[4] || r[5];
            req_tlb_writable = r[6] || r[7];
            place_tags(req_is_load || !r[8] ? -1 : int'(r[10:9]));
            predict();
        end
    endtask

    initial
    begin
        void'($urandom(8919));
        reset = 1'b1;
        req_valid = 1'b0;
        req_is_load = 1'b0;
        req_access = mem_op_pkg::MEM_B;
        req_paddr = '0;
        req_lane_mask = '0;
        req_store_value = '0;
        req_thread_idx = '0;
        req_tlb_hit = 1'b0;
        req_tlb_present = 1'b0;
        req_tlb_writable = 1'b0;
        way_valid = '0;
        way_tag = '0;
        fill_en = 1'b0;
        fill_way = '0;
        fill_set = '0;
        fill_data = '0;
        tag_fill_en = 1'b0;
        tag_fill_set = '0;
        tag_fill_tag = '0;
        predict();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        hit_load_checks(50);
        load_miss_checks(30, 1'b0);
        load_miss_checks(30, 1'b1);
        store_checks(120);
        fault_checks(160);
        @(negedge clk);
        random_request();
        req_valid = 1'b0;
        predict();
        repeat (3) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

    valid_ok: assert property (@(posedge clk) disable iff (reset)
        armed |-> resp_valid == want.valid)
        else mismatch("resp_valid", 512'($sampled(want.valid)), 512'($sampled(resp_valid)));
    thread_ok: assert property (@(posedge clk) disable iff (reset)
        armed && want.valid |-> resp_thread_idx == want.thread)
        else mismatch("resp_thread_idx", 512'($sampled(want.thread)),
            512'($sampled(resp_thread_idx)));
    fault_ok: assert property (@(posedge clk) disable iff (reset)
        armed |-> resp_fault == want.fault)
        else mismatch("resp_fault", 512'($sampled(want.fault)), 512'($sampled(resp_fault)));
    reason_ok: assert property (@(posedge clk) disable iff (reset)
        armed && want.fault |-> resp_fault_reason == want.reason)
        else mismatch("resp_fault_reason", 512'($sampled(want.reason)),
            512'($sampled(resp_fault_reason)));
    suspend_ok: assert property (@(posedge clk) disable iff (reset)
        armed |-> resp_suspend == want.miss)
        else mismatch("resp_suspend", 512'($sampled(want.miss)), 512'($sampled(resp_suspend)));
    rollback_ok: assert property (@(posedge clk) disable iff (reset)
        armed |-> resp_rollback == want.rollback)
        else mismatch("resp_rollback", 512'($sampled(want.rollback)),
            512'($sampled(resp_rollback)));
    lru_en_ok: assert property (@(posedge clk) disable iff (reset)
        armed |-> lru_update_en == want.lru_en)
        else mismatch("lru_update_en", 512'($sampled(want.lru_en)),
            512'($sampled(lru_update_en)));
    lru_way_ok: assert property (@(posedge clk) disable iff (reset)
        armed && want.lru_en |-> lru_update_way == want.lru_way)
        else mismatch("lru_update_way", 512'($sampled(want.lru_way)),
            512'($sampled(lru_update_way)));
    miss_en_ok: assert property (@(posedge clk) disable iff (reset)
        armed |-> miss_en == want.miss)
        else mismatch("miss_en", 512'($sampled(want.miss)), 512'($sampled(miss_en)));
    miss_addr_ok: assert property (@(posedge clk) disable iff (reset)
        armed && want.miss |-> miss_addr == want.miss_addr)
        else mismatch("miss_addr", 512'($sampled(want.miss_addr)), 512'($sampled(miss_addr)));
    miss_thread_ok: assert property (@(posedge clk) disable iff (reset)
        armed && want.miss |-> miss_thread_idx == want.thread)
        else mismatch("miss_thread_idx", 512'($sampled(want.thread)),
            512'($sampled(miss_thread_idx)));
    store_en_ok: assert property (@(posedge clk) disable iff (reset)
        armed |-> store_en == want.store_en)
        else mismatch("store_en", 512'($sampled(want.store_en)), 512'($sampled(store_en)));
    store_addr_ok: assert property (@(posedge clk) disable iff (reset)
        armed && want.store_en |-> store_addr == want.store_addr)
        else mismatch("store_addr", 512'($sampled(want.store_addr)),
            512'($sampled(store_addr)));
    store_mask_ok: assert property (@(posedge clk) disable iff (reset)
        armed && want.store_en |-> store_mask_out == want.store_mask)
        else mismatch("store_mask_out", 512'($sampled(want.store_mask)),
            512'($sampled(store_mask_out)));
    store_data_ok: assert property (@(posedge clk) disable iff (reset)
        armed && want.store_en |-> store_data_out == want.store_data)
        else mismatch("store_data_out", 512'($sampled(want.store_data)),
            512'($sampled(store_data_out)));
    load_data_ok: assert property (@(posedge clk) disable iff (reset)
        armed && want.check_load |-> resp_load_data == want.load_data)
        else mismatch("resp_load_data", 512'($sampled(want.load_data)),
            512'($sampled(resp_load_data)));

endmodule

`default_nettype wire

//--- verilog.f
l1d_geometry_pkg.sv
mem_op_pkg.sv
way_hit_detect.sv
store_align.sv
access_check.sv
line_data_ram.sv
response_register.sv
dcache_data_stage.sv
tb_dcache_data_stage.sv

//--- way_hit_detect.sv
// Tag compare and hit way
`timescale 1ns/1ns
`default_nettype none

module way_hit_detect
(
    input wire logic [l1d_geometry_pkg::ADDR_BITS-1:0] req_paddr,
    input wire logic req_tlb_hit,
    input wire logic [l1d_geometry_pkg::WAYS-1:0] way_valid,
    input wire logic [l1d_geometry_pkg::WAYS-1:0][l1d_geometry_pkg::TAG_BITS-1:0] way_tag,
    input wire logic tag_fill_en,
    input wire logic [l1d_geometry_pkg::SET_BITS-1:0] tag_fill_set,
    input wire logic [l1d_geometry_pkg::TAG_BITS-1:0] tag_fill_tag,
    output logic hit,
    output logic [l1d_geometry_pkg::WAY_IDX_BITS-1:0] hit_way,
    output logic near_miss_tag
);

    logic [l1d_geometry_pkg::TAG_BITS-1:0] req_tag;
    logic [l1d_geometry_pkg::SET_BITS-1:0] req_set;
    logic [l1d_geometry_pkg::WAYS-1:0] hit_oh;

    assign req_tag = req_paddr[l1d_geometry_pkg::ADDR_BITS-1 -: l1d_geometry_pkg::TAG_BITS];
    assign req_set = req_paddr[l1d_geometry_pkg::OFFSET_BITS +: l1d_geometry_pkg::SET_BITS];

    for (genvar w = 0; w < l1d_geometry_pkg::WAYS; w++)
    begin : compare_gen
        assign hit_oh[w] = way_valid[w] && way_tag[w] == req_tag;
    end

    // Tag bits are only meaningful when the translation succeeded
    assign hit = |hit_oh && req_tlb_hit;

    // One-hot to index, OR of the matching way numbers
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < l1d_geometry_pkg::WAYS; w++)
            if (hit_oh[w])
                hit_way = hit_way | w[l1d_geometry_pkg::WAY_IDX_BITS-1:0];
    end

    // L2 is installing this very line right now, the tag arrives next cycle
    assign near_miss_tag = tag_fill_en && tag_fill_set == req_set && tag_fill_tag == req_tag;

    // The tag stage must never hold one line in two ways of a set
    always_comb
    begin
        assert final (!req_tlb_hit || $onehot0(hit_oh));
    end

endmodule

`default_nettype wire
